// File: common/ldu_pkg.sv
// load unit package: queue sizes, field widths, PR bank split and writeback match

package ldu_pkg;

	// ----------------------------------------------------------
	// dispatch and register file
	localparam int DISPATCH_WAYS = 4;
	localparam int LOG_PR_COUNT = 6;
	localparam int PRF_BANK_COUNT = 4;
	localparam int LOG_PRF_BANK_COUNT = 2;
	// PR index with the bank bits stripped off
	localparam int UPPER_PR_WIDTH = LOG_PR_COUNT - LOG_PRF_BANK_COUNT;
	localparam int LOG_ROB_ENTRIES = 6;
	localparam int MDPT_INFO_WIDTH = 8;

	// ----------------------------------------------------------
	// queue depths
	localparam int LDU_DQ_ENTRIES = 4;
	localparam int LOG_LDU_DQ_ENTRIES = 2;
	localparam int LDU_CQ_ENTRIES = 8;
	localparam int LOG_LDU_CQ_ENTRIES = 3;
	localparam int LDU_IQ_ENTRIES = 4;

	// ----------------------------------------------------------
	// op fields
	localparam int OP_WIDTH = 4;
	localparam int IMM_WIDTH = 12;

	// true when some bank is writing back this PR
	// bank is the low bits of the PR, the bus carries the rest
	function automatic logic wb_wakeup(
		input logic [LOG_PR_COUNT-1:0] pr,
		input logic [PRF_BANK_COUNT-1:0] wb_valid,
		input logic [PRF_BANK_COUNT-1:0][UPPER_PR_WIDTH-1:0] wb_upper
	);
		logic [LOG_PRF_BANK_COUNT-1:0] bank;
		bank = pr[LOG_PRF_BANK_COUNT-1:0];
		return wb_valid[bank] && (wb_upper[bank] == pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]);
	endfunction

endpackage

// File: compile.f
+incdir+testbench
common/ldu_pkg.sv
ldu_dq/ldu_dq.sv
src/ldu_cq.sv
src/ldu_iq.sv
src/ldu_dispatch_top.sv
testbench/ldu_dispatch_tb.sv

// File: ldu_dq/ldu_dq.sv
// load dispatch queue: prefix acknowledge, operand A wakeup, in-order dual enqueue to cq and iq

module ldu_dq (
	input logic CLK,
	input logic nRST,

	// dispatch by way
	input logic [ldu_pkg::DISPATCH_WAYS-1:0] dispatch_attempt_by_way,
	input logic [ldu_pkg::DISPATCH_WAYS-1:0] dispatch_valid_by_way,
	input logic [ldu_pkg::DISPATCH_WAYS-1:0][ldu_pkg::OP_WIDTH-1:0] dispatch_op_by_way,
	input logic [ldu_pkg::DISPATCH_WAYS-1:0][ldu_pkg::IMM_WIDTH-1:0] dispatch_imm12_by_way,
	input logic [ldu_pkg::DISPATCH_WAYS-1:0][ldu_pkg::MDPT_INFO_WIDTH-1:0]
		dispatch_mdp_info_by_way,
	input logic [ldu_pkg::DISPATCH_WAYS-1:0][ldu_pkg::LOG_PR_COUNT-1:0] dispatch_A_PR_by_way,
	input logic [ldu_pkg::DISPATCH_WAYS-1:0] dispatch_A_ready_by_way,
	input logic [ldu_pkg::DISPATCH_WAYS-1:0] dispatch_A_is_zero_by_way,
	input logic [ldu_pkg::DISPATCH_WAYS-1:0][ldu_pkg::LOG_PR_COUNT-1:0] dispatch_dest_PR_by_way,
	input logic [ldu_pkg::DISPATCH_WAYS-1:0][ldu_pkg::LOG_ROB_ENTRIES-1:0]
		dispatch_ROB_index_by_way,
	output logic [ldu_pkg::DISPATCH_WAYS-1:0] dispatch_ack_by_way,

	// writeback bus
	input logic [ldu_pkg::PRF_BANK_COUNT-1:0] WB_bus_valid_by_bank,
	input logic [ldu_pkg::PRF_BANK_COUNT-1:0][ldu_pkg::UPPER_PR_WIDTH-1:0] WB_bus_upper_PR_by_bank,

	// central queue enqueue
	output logic ldu_cq_enq_valid,
	output logic [ldu_pkg::MDPT_INFO_WIDTH-1:0] ldu_cq_enq_mdp_info,
	output logic [ldu_pkg::LOG_PR_COUNT-1:0] ldu_cq_enq_dest_PR,
	output logic [ldu_pkg::LOG_ROB_ENTRIES-1:0] ldu_cq_enq_ROB_index,
	input logic ldu_cq_enq_ready,
	input logic [ldu_pkg::LOG_LDU_CQ_ENTRIES-1:0] ldu_cq_enq_index,

	// issue queue enqueue
	output logic ldu_iq_enq_valid,
	output logic [ldu_pkg::OP_WIDTH-1:0] ldu_iq_enq_op,
	output logic [ldu_pkg::IMM_WIDTH-1:0] ldu_iq_enq_imm12,
	output logic [ldu_pkg::LOG_PR_COUNT-1:0] ldu_iq_enq_A_PR,
	output logic ldu_iq_enq_A_ready,
	output logic ldu_iq_enq_A_is_zero,
	output logic [ldu_pkg::LOG_LDU_CQ_ENTRIES-1:0] ldu_iq_enq_cq_index,
	input logic ldu_iq_enq_ready,

	input logic rob_restart_valid
);

	// entry storage
	logic [ldu_pkg::OP_WIDTH-1:0] op_q [ldu_pkg::LDU_DQ_ENTRIES];
	logic [ldu_pkg::IMM_WIDTH-1:0] imm12_q [ldu_pkg::LDU_DQ_ENTRIES];
	logic [ldu_pkg::MDPT_INFO_WIDTH-1:0] mdp_info_q [ldu_pkg::LDU_DQ_ENTRIES];
	logic [ldu_pkg::LOG_PR_COUNT-1:0] A_PR_q [ldu_pkg::LDU_DQ_ENTRIES];
	logic A_ready_q [ldu_pkg::LDU_DQ_ENTRIES];
	logic A_is_zero_q [ldu_pkg::LDU_DQ_ENTRIES];
	logic [ldu_pkg::LOG_PR_COUNT-1:0] dest_PR_q [ldu_pkg::LDU_DQ_ENTRIES];
	logic [ldu_pkg::LOG_ROB_ENTRIES-1:0] ROB_index_q [ldu_pkg::LDU_DQ_ENTRIES];

	// ring control
	logic [ldu_pkg::LOG_LDU_DQ_ENTRIES-1:0] head_q;
	logic [ldu_pkg::LOG_LDU_DQ_ENTRIES-1:0] tail_q;
	logic [ldu_pkg::LOG_LDU_DQ_ENTRIES:0] count_q;
	logic [ldu_pkg::LOG_LDU_DQ_ENTRIES:0] free_count;

	logic [ldu_pkg::DISPATCH_WAYS-1:0] enq_by_way;
	logic [ldu_pkg::DISPATCH_WAYS-1:0][ldu_pkg::LOG_LDU_DQ_ENTRIES-1:0] enq_slot_by_way;
	logic [ldu_pkg::LOG_LDU_DQ_ENTRIES:0] enq_count;
	logic deq;

	// ----------------------------------------------------------
	// dispatch acceptance

	// free slots as of the start of the cycle, dequeue not counted
	assign free_count = (ldu_pkg::LOG_LDU_DQ_ENTRIES+1)'(ldu_pkg::LDU_DQ_ENTRIES) - count_q;

	always_comb begin
		logic blocked;
		blocked = rob_restart_valid;
		enq_count = '0;
		dispatch_ack_by_way = '0;
		enq_by_way = '0;
		enq_slot_by_way = '0;
		for (int w = 0; w < ldu_pkg::DISPATCH_WAYS; w++) begin
			if (dispatch_attempt_by_way[w] && !blocked) begin
				if (!dispatch_valid_by_way[w]) begin
					// bubble inside the prefix, no slot needed
					dispatch_ack_by_way[w] = 1'b1;
				end else if (enq_count < free_count) begin
					dispatch_ack_by_way[w] = 1'b1;
					enq_by_way[w] = 1'b1;
					enq_slot_by_way[w] = tail_q + enq_count[ldu_pkg::LOG_LDU_DQ_ENTRIES-1:0];
					enq_count = enq_count + (ldu_pkg::LOG_LDU_DQ_ENTRIES+1)'(1);
				end else begin
					blocked = 1'b1;
				end
			end
		end
	end

	// ----------------------------------------------------------
	// head move into cq and iq together

	assign deq = (count_q != '0) && ldu_cq_enq_ready && ldu_iq_enq_ready && !rob_restart_valid;

	assign ldu_cq_enq_valid = deq;
	assign ldu_cq_enq_mdp_info = mdp_info_q[head_q];
	assign ldu_cq_enq_dest_PR = dest_PR_q[head_q];
	assign ldu_cq_enq_ROB_index = ROB_index_q[head_q];

	assign ldu_iq_enq_valid = deq;
	assign ldu_iq_enq_op = op_q[head_q];
	assign ldu_iq_enq_imm12 = imm12_q[head_q];
	assign ldu_iq_enq_A_PR = A_PR_q[head_q];
	// catch a writeback landing during the move
	assign ldu_iq_enq_A_ready = A_ready_q[head_q]
		| ldu_pkg::wb_wakeup(A_PR_q[head_q], WB_bus_valid_by_bank, WB_bus_upper_PR_by_bank);
	assign ldu_iq_enq_A_is_zero = A_is_zero_q[head_q];
	// iq op carries the slot cq grants this cycle
	assign ldu_iq_enq_cq_index = ldu_cq_enq_index;

	// ----------------------------------------------------------
	// entry writes and wakeup

	always_ff @(posedge CLK) begin
		for (int i = 0; i < ldu_pkg::LDU_DQ_ENTRIES; i++) begin
			if (ldu_pkg::wb_wakeup(A_PR_q[i], WB_bus_valid_by_bank, WB_bus_upper_PR_by_bank)) begin
				A_ready_q[i] <= 1'b1;
			end
		end
		for (int w = 0; w < ldu_pkg::DISPATCH_WAYS; w++) begin
			if (enq_by_way[w]) begin
				op_q[enq_slot_by_way[w]] <= dispatch_op_by_way[w];
				imm12_q[enq_slot_by_way[w]] <= dispatch_imm12_by_way[w];
				mdp_info_q[enq_slot_by_way[w]] <= dispatch_mdp_info_by_way[w];
				A_PR_q[enq_slot_by_way[w]] <= dispatch_A_PR_by_way[w];
				A_ready_q[enq_slot_by_way[w]] <= dispatch_A_ready_by_way[w]
					| ldu_pkg::wb_wakeup(dispatch_A_PR_by_way[w], WB_bus_valid_by_bank,
						WB_bus_upper_PR_by_bank);
				A_is_zero_q[enq_slot_by_way[w]] <= dispatch_A_is_zero_by_way[w];
				dest_PR_q[enq_slot_by_way[w]] <= dispatch_dest_PR_by_way[w];
				ROB_index_q[enq_slot_by_way[w]] <= dispatch_ROB_index_by_way[w];
			end
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			head_q <= '0;
			tail_q <= '0;
			count_q <= '0;
		end else if (rob_restart_valid) begin
			head_q <= '0;
			tail_q <= '0;
			count_q <= '0;
		end else begin
			if (deq) begin
				head_q <= head_q + ldu_pkg::LOG_LDU_DQ_ENTRIES'(1);
			end
			tail_q <= tail_q + enq_count[ldu_pkg::LOG_LDU_DQ_ENTRIES-1:0];
			count_q <= count_q + enq_count - (ldu_pkg::LOG_LDU_DQ_ENTRIES+1)'(deq);
		end
	end

	// acks never push the ring past its slot count
	ack_within_free: assert property (@(posedge CLK) disable iff (!nRST)
		count_q <= (ldu_pkg::LOG_LDU_DQ_ENTRIES+1)'(ldu_pkg::LDU_DQ_ENTRIES));

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the load dispatch testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module ldu_dispatch_tb -o ldu_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/ldu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Something failed" "$LOG"; then
	exit 1
fi
exit 0

// File: src/ldu_cq.sv
// load central queue: in-order index allocation, head view and retire

module ldu_cq (
	input logic CLK,
	input logic nRST,

	// enqueue from dq
	input logic ldu_cq_enq_valid,
	input logic [ldu_pkg::MDPT_INFO_WIDTH-1:0] ldu_cq_enq_mdp_info,
	input logic [ldu_pkg::LOG_PR_COUNT-1:0] ldu_cq_enq_dest_PR,
	input logic [ldu_pkg::LOG_ROB_ENTRIES-1:0] ldu_cq_enq_ROB_index,
	output logic ldu_cq_enq_ready,
	output logic [ldu_pkg::LOG_LDU_CQ_ENTRIES-1:0] ldu_cq_enq_index,

	// oldest entry
	output logic cq_head_valid,
	output logic [ldu_pkg::LOG_PR_COUNT-1:0] cq_head_dest_PR,
	output logic [ldu_pkg::LOG_ROB_ENTRIES-1:0] cq_head_ROB_index,
	output logic [ldu_pkg::MDPT_INFO_WIDTH-1:0] cq_head_mdp_info,

	input logic retire,
	input logic rob_restart_valid
);

	logic [ldu_pkg::MDPT_INFO_WIDTH-1:0] mdp_info_q [ldu_pkg::LDU_CQ_ENTRIES];
	logic [ldu_pkg::LOG_PR_COUNT-1:0] dest_PR_q [ldu_pkg::LDU_CQ_ENTRIES];
	logic [ldu_pkg::LOG_ROB_ENTRIES-1:0] ROB_index_q [ldu_pkg::LDU_CQ_ENTRIES];

	logic [ldu_pkg::LOG_LDU_CQ_ENTRIES-1:0] head_q;
	logic [ldu_pkg::LOG_LDU_CQ_ENTRIES-1:0] tail_q;
	logic [ldu_pkg::LOG_LDU_CQ_ENTRIES:0] count_q;
	logic enq;
	logic deq;

	assign ldu_cq_enq_ready = count_q != (ldu_pkg::LOG_LDU_CQ_ENTRIES+1)'(ldu_pkg::LDU_CQ_ENTRIES);
	// the tail is the index handed to the incoming op
	assign ldu_cq_enq_index = tail_q;

	assign cq_head_valid = count_q != '0;
	assign cq_head_dest_PR = dest_PR_q[head_q];
	assign cq_head_ROB_index = ROB_index_q[head_q];
	assign cq_head_mdp_info = mdp_info_q[head_q];

	assign enq = ldu_cq_enq_valid && ldu_cq_enq_ready;
	// retire on empty is dropped here
	assign deq = retire && cq_head_valid;

	always_ff @(posedge CLK) begin
		if (enq) begin
			mdp_info_q[tail_q] <= ldu_cq_enq_mdp_info;
			dest_PR_q[tail_q] <= ldu_cq_enq_dest_PR;
			ROB_index_q[tail_q] <= ldu_cq_enq_ROB_index;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			head_q <= '0;
			tail_q <= '0;
			count_q <= '0;
		end else if (rob_restart_valid) begin
			head_q <= '0;
			tail_q <= '0;
			count_q <= '0;
		end else begin
			if (enq) begin
				tail_q <= tail_q + ldu_pkg::LOG_LDU_CQ_ENTRIES'(1);
			end
			if (deq) begin
				head_q <= head_q + ldu_pkg::LOG_LDU_CQ_ENTRIES'(1);
			end
			count_q <= count_q + (ldu_pkg::LOG_LDU_CQ_ENTRIES+1)'(enq)
				- (ldu_pkg::LOG_LDU_CQ_ENTRIES+1)'(deq);
		end
	end

	// dq must hold its head while cq is full
	no_enq_when_full: assert property (@(posedge CLK) disable iff (!nRST)
		ldu_cq_enq_valid |-> ldu_cq_enq_ready);

endmodule

// File: src/ldu_dispatch_top.sv
// load dispatch front end top: dispatch queue feeding central queue and issue queue

module ldu_dispatch_top (
	input logic CLK,
	input logic nRST,

	// dispatch by way
	input logic [ldu_pkg::DISPATCH_WAYS-1:0] dispatch_attempt_by_way,
	input logic [ldu_pkg::DISPATCH_WAYS-1:0] dispatch_valid_by_way,
	input logic [ldu_pkg::DISPATCH_WAYS-1:0][ldu_pkg::OP_WIDTH-1:0] dispatch_op_by_way,
	input logic [ldu_pkg::DISPATCH_WAYS-1:0][ldu_pkg::IMM_WIDTH-1:0] dispatch_imm12_by_way,
	input logic [ldu_pkg::DISPATCH_WAYS-1:0][ldu_pkg::MDPT_INFO_WIDTH-1:0]
		dispatch_mdp_info_by_way,
	input logic [ldu_pkg::DISPATCH_WAYS-1:0][ldu_pkg::LOG_PR_COUNT-1:0] dispatch_A_PR_by_way,
	input logic [ldu_pkg::DISPATCH_WAYS-1:0] dispatch_A_ready_by_way,
	input logic [ldu_pkg::DISPATCH_WAYS-1:0] dispatch_A_is_zero_by_way,
	input logic [ldu_pkg::DISPATCH_WAYS-1:0][ldu_pkg::LOG_PR_COUNT-1:0] dispatch_dest_PR_by_way,
	input logic [ldu_pkg::DISPATCH_WAYS-1:0][ldu_pkg::LOG_ROB_ENTRIES-1:0]
		dispatch_ROB_index_by_way,
	output logic [ldu_pkg::DISPATCH_WAYS-1:0] dispatch_ack_by_way,

	// writeback bus
	input logic [ldu_pkg::PRF_BANK_COUNT-1:0] WB_bus_valid_by_bank,
	input logic [ldu_pkg::PRF_BANK_COUNT-1:0][ldu_pkg::UPPER_PR_WIDTH-1:0] WB_bus_upper_PR_by_bank,

	// issue
	output logic issue_valid,
	output logic [ldu_pkg::OP_WIDTH-1:0] issue_op,
	output logic [ldu_pkg::IMM_WIDTH-1:0] issue_imm12,
	output logic [ldu_pkg::LOG_PR_COUNT-1:0] issue_A_PR,
	output logic [ldu_pkg::LOG_LDU_CQ_ENTRIES-1:0] issue_cq_index,

	// central queue head and retire
	output logic cq_head_valid,
	output logic [ldu_pkg::LOG_PR_COUNT-1:0] cq_head_dest_PR,
	output logic [ldu_pkg::LOG_ROB_ENTRIES-1:0] cq_head_ROB_index,
	output logic [ldu_pkg::MDPT_INFO_WIDTH-1:0] cq_head_mdp_info,
	input logic retire,

	input logic rob_restart_valid
);

	// ----------------------------------------------------------
	// dq to cq
	logic ldu_cq_enq_valid;
	logic [ldu_pkg::MDPT_INFO_WIDTH-1:0] ldu_cq_enq_mdp_info;
	logic [ldu_pkg::LOG_PR_COUNT-1:0] ldu_cq_enq_dest_PR;
	logic [ldu_pkg::LOG_ROB_ENTRIES-1:0] ldu_cq_enq_ROB_index;
	logic ldu_cq_enq_ready;
	logic [ldu_pkg::LOG_LDU_CQ_ENTRIES-1:0] ldu_cq_enq_index;

	// ----------------------------------------------------------
	// dq to iq
	logic ldu_iq_enq_valid;
	logic [ldu_pkg::OP_WIDTH-1:0] ldu_iq_enq_op;
	logic [ldu_pkg::IMM_WIDTH-1:0] ldu_iq_enq_imm12;
	logic [ldu_pkg::LOG_PR_COUNT-1:0] ldu_iq_enq_A_PR;
	logic ldu_iq_enq_A_ready;
	logic ldu_iq_enq_A_is_zero;
	logic [ldu_pkg::LOG_LDU_CQ_ENTRIES-1:0] ldu_iq_enq_cq_index;
	logic ldu_iq_enq_ready;

	// names line up across all three blocks
	ldu_dq ldu_dq_i (.*);

	ldu_cq ldu_cq_i (.*);

	ldu_iq ldu_iq_i (.*);

endmodule

// File: src/ldu_iq.sv
// load issue queue: age-ordered collapsing queue with writeback wakeup and oldest-ready issue

module ldu_iq (
	input logic CLK,
	input logic nRST,

	// enqueue from dq
	input logic ldu_iq_enq_valid,
	input logic [ldu_pkg::OP_WIDTH-1:0] ldu_iq_enq_op,
	input logic [ldu_pkg::IMM_WIDTH-1:0] ldu_iq_enq_imm12,
	input logic [ldu_pkg::LOG_PR_COUNT-1:0] ldu_iq_enq_A_PR,
	input logic ldu_iq_enq_A_ready,
	input logic ldu_iq_enq_A_is_zero,
	input logic [ldu_pkg::LOG_LDU_CQ_ENTRIES-1:0] ldu_iq_enq_cq_index,
	output logic ldu_iq_enq_ready,

	// writeback bus
	input logic [ldu_pkg::PRF_BANK_COUNT-1:0] WB_bus_valid_by_bank,
	input logic [ldu_pkg::PRF_BANK_COUNT-1:0][ldu_pkg::UPPER_PR_WIDTH-1:0] WB_bus_upper_PR_by_bank,

	// issue strobe
	output logic issue_valid,
	output logic [ldu_pkg::OP_WIDTH-1:0] issue_op,
	output logic [ldu_pkg::IMM_WIDTH-1:0] issue_imm12,
	output logic [ldu_pkg::LOG_PR_COUNT-1:0] issue_A_PR,
	output logic [ldu_pkg::LOG_LDU_CQ_ENTRIES-1:0] issue_cq_index,

	input logic rob_restart_valid
);

	// entry 0 is the oldest, valid entries stay packed at the bottom
	logic [ldu_pkg::LDU_IQ_ENTRIES-1:0] valid_q;
	logic [ldu_pkg::OP_WIDTH-1:0] op_q [ldu_pkg::LDU_IQ_ENTRIES];
	logic [ldu_pkg::IMM_WIDTH-1:0] imm12_q [ldu_pkg::LDU_IQ_ENTRIES];
	logic [ldu_pkg::LOG_PR_COUNT-1:0] A_PR_q [ldu_pkg::LDU_IQ_ENTRIES];
	logic A_ready_q [ldu_pkg::LDU_IQ_ENTRIES];
	logic A_is_zero_q [ldu_pkg::LDU_IQ_ENTRIES];
	logic [ldu_pkg::LOG_LDU_CQ_ENTRIES-1:0] cq_index_q [ldu_pkg::LDU_IQ_ENTRIES];

	logic [ldu_pkg::LDU_IQ_ENTRIES-1:0] valid_n;
	logic [ldu_pkg::OP_WIDTH-1:0] op_n [ldu_pkg::LDU_IQ_ENTRIES];
	logic [ldu_pkg::IMM_WIDTH-1:0] imm12_n [ldu_pkg::LDU_IQ_ENTRIES];
	logic [ldu_pkg::LOG_PR_COUNT-1:0] A_PR_n [ldu_pkg::LDU_IQ_ENTRIES];
	logic A_ready_n [ldu_pkg::LDU_IQ_ENTRIES];
	logic A_is_zero_n [ldu_pkg::LDU_IQ_ENTRIES];
	logic [ldu_pkg::LOG_LDU_CQ_ENTRIES-1:0] cq_index_n [ldu_pkg::LDU_IQ_ENTRIES];

	logic [ldu_pkg::LDU_IQ_ENTRIES-1:0] issue_sel;

	assign ldu_iq_enq_ready = !valid_q[ldu_pkg::LDU_IQ_ENTRIES-1];

	always_comb begin
		logic found;
		logic shifting;
		logic placed;
		int src;
		found = 1'b0;
		shifting = 1'b0;
		placed = 1'b0;
		src = 0;
		issue_sel = '0;

		// ------------------------------------------------------
		// oldest ready select
		for (int i = 0; i < ldu_pkg::LDU_IQ_ENTRIES; i++) begin
			if (!found && valid_q[i] && (A_ready_q[i] || A_is_zero_q[i])) begin
				issue_sel[i] = 1'b1;
				found = 1'b1;
			end
		end
		issue_valid = found && !rob_restart_valid;

		issue_op = '0;
		issue_imm12 = '0;
		issue_A_PR = '0;
		issue_cq_index = '0;
		for (int i = 0; i < ldu_pkg::LDU_IQ_ENTRIES; i++) begin
			if (issue_sel[i]) begin
				issue_op = op_q[i];
				issue_imm12 = imm12_q[i];
				issue_A_PR = A_PR_q[i];
				issue_cq_index = cq_index_q[i];
			end
		end

		// ------------------------------------------------------
		// collapse above the issued entry, wake on writeback
		for (int i = 0; i < ldu_pkg::LDU_IQ_ENTRIES; i++) begin
			if (issue_valid && issue_sel[i]) begin
				shifting = 1'b1;
			end
			src = (shifting && i < ldu_pkg::LDU_IQ_ENTRIES - 1) ? i + 1 : i;
			valid_n[i] = (shifting && i == ldu_pkg::LDU_IQ_ENTRIES - 1) ? 1'b0 : valid_q[src];
			op_n[i] = op_q[src];
			imm12_n[i] = imm12_q[src];
			A_PR_n[i] = A_PR_q[src];
			A_ready_n[i] = A_ready_q[src]
				| ldu_pkg::wb_wakeup(A_PR_q[src], WB_bus_valid_by_bank, WB_bus_upper_PR_by_bank);
			A_is_zero_n[i] = A_is_zero_q[src];
			cq_index_n[i] = cq_index_q[src];
		end

		// new op lands in the lowest free slot after collapse
		if (ldu_iq_enq_valid && ldu_iq_enq_ready) begin
			for (int i = 0; i < ldu_pkg::LDU_IQ_ENTRIES; i++) begin
				if (!placed && !valid_n[i]) begin
					valid_n[i] = 1'b1;
					op_n[i] = ldu_iq_enq_op;
					imm12_n[i] = ldu_iq_enq_imm12;
					A_PR_n[i] = ldu_iq_enq_A_PR;
					A_ready_n[i] = ldu_iq_enq_A_ready;
					A_is_zero_n[i] = ldu_iq_enq_A_is_zero;
					cq_index_n[i] = ldu_iq_enq_cq_index;
					placed = 1'b1;
				end
			end
		end

		if (rob_restart_valid) begin
			valid_n = '0;
		end
	end

	always_ff @(posedge CLK) begin
		op_q <= op_n;
		imm12_q <= imm12_n;
		A_PR_q <= A_PR_n;
		A_ready_q <= A_ready_n;
		A_is_zero_q <= A_is_zero_n;
		cq_index_q <= cq_index_n;
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_q <= '0;
		end else begin
			valid_q <= valid_n;
		end
	end

	// dq must hold its head while iq is full
	no_enq_when_full: assert property (@(posedge CLK) disable iff (!nRST)
		ldu_iq_enq_valid |-> ldu_iq_enq_ready);

endmodule

// File: testbench/ldu_dispatch_ref.svh
// reference model: expected issue and cq records, writeback match, model updates, LFSR source

`ifndef LDU_DISPATCH_REF_SVH
`define LDU_DISPATCH_REF_SVH

typedef struct packed {
	logic [ldu_pkg::OP_WIDTH-1:0] op;
	logic [ldu_pkg::IMM_WIDTH-1:0] imm12;
	logic [ldu_pkg::LOG_PR_COUNT-1:0] A_PR;
	logic [ldu_pkg::LOG_LDU_CQ_ENTRIES-1:0] cq_index;
	logic ready;
} issue_rec_t;

typedef struct packed {
	logic [ldu_pkg::LOG_PR_COUNT-1:0] dest_PR;
	logic [ldu_pkg::LOG_ROB_ENTRIES-1:0] ROB_index;
	logic [ldu_pkg::MDPT_INFO_WIDTH-1:0] mdp_info;
} cq_rec_t;

// acked ops in dispatch order
issue_rec_t exp_issue [$];
cq_rec_t exp_cq [$];
logic [ldu_pkg::LOG_LDU_CQ_ENTRIES-1:0] cq_next = '0;
logic [63:0] pr_written = '0;
logic [31:0] lfsr_state = 32'hca70bbc4;

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic lfsr_bit();
	logic b;
	b = lfsr_state[0];
	lfsr_state = lfsr_state >> 1;
	if (b) begin
		lfsr_state = lfsr_state ^ 32'h80200003;
	end
	return b;
endfunction

function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		v[i] = lfsr_bit();
	end
	return v;
endfunction

// PR p lives in bank p mod 4 with upper value p div 4
function automatic logic wb_hits(input int pr, input logic [3:0] v, input logic [3:0][3:0] u);
	return v[pr % 4] && (int'(u[pr % 4]) == pr / 4);
endfunction

function automatic int first_ready_index();
	for (int i = 0; i < exp_issue.size(); i++) begin
		if (exp_issue[i].ready) begin
			return i;
		end
	end
	return -1;
endfunction

function automatic void model_writeback(input logic [3:0] v, input logic [3:0][3:0] u);
	for (int i = 0; i < exp_issue.size(); i++) begin
		if (wb_hits(int'(exp_issue[i].A_PR), v, u)) begin
			exp_issue[i].ready = 1'b1;
		end
	end
	for (int b = 0; b < 4; b++) begin
		if (v[b]) begin
			pr_written[int'(u[b]) * 4 + b] = 1'b1;
		end
	end
endfunction

// acked valid ways take cq indices in order
function automatic void model_accept();
	issue_rec_t r;
	cq_rec_t c;
	for (int w = 0; w < ldu_pkg::DISPATCH_WAYS; w++) begin
		if (dispatch_ack_by_way[w] && dispatch_valid_by_way[w] && !rob_restart_valid) begin
			r.op = dispatch_op_by_way[w];
			r.imm12 = dispatch_imm12_by_way[w];
			r.A_PR = dispatch_A_PR_by_way[w];
			r.cq_index = cq_next;
			r.ready = dispatch_A_ready_by_way[w] || dispatch_A_is_zero_by_way[w]
				|| wb_hits(int'(dispatch_A_PR_by_way[w]), WB_bus_valid_by_bank,
					WB_bus_upper_PR_by_bank);
			c.dest_PR = dispatch_dest_PR_by_way[w];
			c.ROB_index = dispatch_ROB_index_by_way[w];
			c.mdp_info = dispatch_mdp_info_by_way[w];
			exp_issue.push_back(r);
			exp_cq.push_back(c);
			cq_next = cq_next + 1'b1;
		end
	end
endfunction

function automatic void model_flush();
	exp_issue.delete();
	exp_cq.delete();
	cq_next = '0;
endfunction

`endif

// File: testbench/ldu_dispatch_tb.sv
// testbench for the load dispatch front end: clock, reset, stimulus, comparison and tests

module ldu_dispatch_tb;

	logic CLK = 1'b0;
	logic nRST;
	logic [3:0] dispatch_attempt_by_way;
	logic [3:0] dispatch_valid_by_way;
	logic [3:0][ldu_pkg::OP_WIDTH-1:0] dispatch_op_by_way;
	logic [3:0][ldu_pkg::IMM_WIDTH-1:0] dispatch_imm12_by_way;
	logic [3:0][ldu_pkg::MDPT_INFO_WIDTH-1:0] dispatch_mdp_info_by_way;
	logic [3:0][ldu_pkg::LOG_PR_COUNT-1:0] dispatch_A_PR_by_way;
	logic [3:0] dispatch_A_ready_by_way;
	logic [3:0] dispatch_A_is_zero_by_way;
	logic [3:0][ldu_pkg::LOG_PR_COUNT-1:0] dispatch_dest_PR_by_way;
	logic [3:0][ldu_pkg::LOG_ROB_ENTRIES-1:0] dispatch_ROB_index_by_way;
	logic [3:0] dispatch_ack_by_way;
	logic [3:0] WB_bus_valid_by_bank;
	logic [3:0][3:0] WB_bus_upper_PR_by_bank;
	logic issue_valid;
	logic [ldu_pkg::OP_WIDTH-1:0] issue_op;
	logic [ldu_pkg::IMM_WIDTH-1:0] issue_imm12;
	logic [ldu_pkg::LOG_PR_COUNT-1:0] issue_A_PR;
	logic [ldu_pkg::LOG_LDU_CQ_ENTRIES-1:0] issue_cq_index;
	logic cq_head_valid;
	logic [ldu_pkg::LOG_PR_COUNT-1:0] cq_head_dest_PR;
	logic [ldu_pkg::LOG_ROB_ENTRIES-1:0] cq_head_ROB_index;
	logic [ldu_pkg::MDPT_INFO_WIDTH-1:0] cq_head_mdp_info;
	logic retire;
	logic rob_restart_valid;

	int error_count = 0;
	int check_count = 0;
	int n_tests = 0;
	int n_failed = 0;
	bit timed_out = 1'b0;
	logic [3:0] last_ack = '0;

	// ops waiting to be sent, in dispatch order
	logic [ldu_pkg::OP_WIDTH-1:0] list_op [32];
	logic [ldu_pkg::IMM_WIDTH-1:0] list_imm [32];
	logic [ldu_pkg::MDPT_INFO_WIDTH-1:0] list_mdp [32];
	logic [ldu_pkg::LOG_PR_COUNT-1:0] list_pr [32];
	logic [ldu_pkg::LOG_PR_COUNT-1:0] list_dest [32];
	logic [ldu_pkg::LOG_ROB_ENTRIES-1:0] list_rob [32];
	logic list_ready [32];
	logic list_zero [32];

	`include "ldu_dispatch_ref.svh"

	ldu_dispatch_top dut_i (.*);

	always #2 CLK = ~CLK;

	function automatic void fail_value(input string msg);
		$display("FAIL t=%0t: %s", $time, msg);
		error_count++;
	endfunction

	function automatic void note_timeout(input string msg);
		$display("timeout at %0t: %s", $time, msg);
		timed_out = 1'b1;
	endfunction

	// ------------------------------------------------------------
	// comparison against the model

	function automatic void compare_issue();
		int i;
		if (!issue_valid) begin
			return;
		end
		check_count++;
		i = first_ready_index();
		if (rob_restart_valid) begin
			fail_value("issue during restart");
		end else if (i < 0) begin
			fail_value($sformatf("unexpected issue op %0h cq %0d", issue_op, issue_cq_index));
		end else begin
			if (issue_op !== exp_issue[i].op || issue_imm12 !== exp_issue[i].imm12
				|| issue_A_PR !== exp_issue[i].A_PR || issue_cq_index !== exp_issue[i].cq_index) begin
				fail_value($sformatf("issue %0h/%0h/%0d/%0d, expected %0h/%0h/%0d/%0d",
					issue_op, issue_imm12, issue_A_PR, issue_cq_index, exp_issue[i].op,
					exp_issue[i].imm12, exp_issue[i].A_PR, exp_issue[i].cq_index));
			end
			exp_issue.delete(i);
		end
	endfunction

	function automatic void compare_retire();
		if (!retire) begin
			return;
		end
		check_count++;
		if (exp_cq.size() == 0) begin
			if (cq_head_valid) begin
				fail_value("cq head valid while model cq is empty");
			end
		end else begin
			if (!cq_head_valid || cq_head_dest_PR !== exp_cq[0].dest_PR
				|| cq_head_ROB_index !== exp_cq[0].ROB_index
				|| cq_head_mdp_info !== exp_cq[0].mdp_info) begin
				fail_value($sformatf("cq head %0b %0d/%0d/%0h, expected %0d/%0d/%0h",
					cq_head_valid, cq_head_dest_PR, cq_head_ROB_index, cq_head_mdp_info,
					exp_cq[0].dest_PR, exp_cq[0].ROB_index, exp_cq[0].mdp_info));
			end
			void'(exp_cq.pop_front());
		end
	endfunction

	function automatic void compare_acks();
		logic [3:0] a;
		a = dispatch_ack_by_way;
		check_count++;
		// acks must be a low prefix of the attempting ways
		if ((a & ~dispatch_attempt_by_way) != 0 || ((a + 4'd1) & a) != 0
			|| (rob_restart_valid && a != 0)) begin
			fail_value($sformatf("ack %b for attempt %b", a, dispatch_attempt_by_way));
		end
	endfunction

	always @(posedge CLK) begin
		if (nRST) begin
			last_ack = dispatch_ack_by_way;
			compare_issue();
			compare_retire();
			compare_acks();
			model_writeback(WB_bus_valid_by_bank, WB_bus_upper_PR_by_bank);
			model_accept();
			if (rob_restart_valid) begin
				model_flush();
			end
		end
	end

	// ------------------------------------------------------------
	// stimulus, all driven after a falling edge

	task automatic clear_dispatch();
		dispatch_attempt_by_way = '0;
		dispatch_valid_by_way = '0;
		WB_bus_valid_by_bank = '0;
		WB_bus_upper_PR_by_bank = '0;
		retire = 1'b0;
	endtask

	// mode 0 never ready, 1 always ready, 2 mixed with some zero operands
	task automatic build_ops(input int n, input int mode);
		for (int k = 0; k < n; k++) begin
			list_op[k] = ldu_pkg::OP_WIDTH'(rand_bits(ldu_pkg::OP_WIDTH));
			list_imm[k] = ldu_pkg::IMM_WIDTH'(rand_bits(ldu_pkg::IMM_WIDTH));
			list_mdp[k] = ldu_pkg::MDPT_INFO_WIDTH'(rand_bits(ldu_pkg::MDPT_INFO_WIDTH));
			list_pr[k] = ldu_pkg::LOG_PR_COUNT'(rand_bits(ldu_pkg::LOG_PR_COUNT));
			list_dest[k] = ldu_pkg::LOG_PR_COUNT'(rand_bits(ldu_pkg::LOG_PR_COUNT));
			list_rob[k] = ldu_pkg::LOG_ROB_ENTRIES'(rand_bits(ldu_pkg::LOG_ROB_ENTRIES));
			list_ready[k] = (mode == 1) || (mode == 2 && rand_bits(2) == 0);
			list_zero[k] = (mode == 2) && (rand_bits(3) == 0);
		end
	endtask

	// writeback to one waiting PR and a retire when the cq shows a head
	task automatic drive_side(input bit wb_en, input bit ret_en);
		int n;
		int start;
		int pick;
		logic [5:0] p;
		WB_bus_valid_by_bank = '0;
		WB_bus_upper_PR_by_bank = '0;
		retire = ret_en && cq_head_valid && rand_bits(1);
		n = exp_issue.size();
		pick = -1;
		if (wb_en && n > 0 && rand_bits(1)) begin
			start = int'(rand_bits(4)) % n;
			for (int j = 0; j < n; j++) begin
				if (pick < 0 && !exp_issue[(start + j) % n].ready) begin
					pick = (start + j) % n;
				end
			end
		end
		if (pick >= 0) begin
			p = exp_issue[pick].A_PR;
			WB_bus_valid_by_bank[p[1:0]] = 1'b1;
			WB_bus_upper_PR_by_bank[p[1:0]] = p[5:2];
		end
	endtask

	task automatic send_ops(input int first, input int n, input bit wb_en, input bit ret_en,
		input bit bub_en, input int stall_limit, output int reached);
		int k;
		int stall;
		int idx [4];
		reached = first;
		stall = 0;
		while (reached < n && stall < stall_limit && !timed_out) begin
			k = reached;
			clear_dispatch();
			for (int w = 0; w < 4; w++) begin
				idx[w] = -1;
				if (k < n && bub_en && w > 0 && rand_bits(2) == 0) begin
					// bubble way, no slot needed
					dispatch_attempt_by_way[w] = 1'b1;
				end else if (k < n) begin
					idx[w] = k;
					dispatch_attempt_by_way[w] = 1'b1;
					dispatch_valid_by_way[w] = 1'b1;
					dispatch_op_by_way[w] = list_op[k];
					dispatch_imm12_by_way[w] = list_imm[k];
					dispatch_mdp_info_by_way[w] = list_mdp[k];
					dispatch_A_PR_by_way[w] = list_pr[k];
					dispatch_A_ready_by_way[w] = list_ready[k] || pr_written[list_pr[k]];
					dispatch_A_is_zero_by_way[w] = list_zero[k];
					dispatch_dest_PR_by_way[w] = list_dest[k];
					dispatch_ROB_index_by_way[w] = list_rob[k];
					k++;
				end
			end
			drive_side(wb_en, ret_en);
			@(negedge CLK);
			stall++;
			for (int w = 0; w < 4; w++) begin
				if (last_ack[w] && idx[w] >= 0) begin
					reached = idx[w] + 1;
					stall = 0;
				end
			end
		end
		clear_dispatch();
	endtask

	task automatic drain_issue(input int limit, input bit ret_en);
		int cycles;
		cycles = 0;
		while (exp_issue.size() > 0 && !timed_out) begin
			if (cycles >= limit) begin
				note_timeout("ops still waiting to issue");
			end else begin
				drive_side(1'b1, ret_en);
				@(negedge CLK);
				cycles++;
			end
		end
		clear_dispatch();
	endtask

	task automatic drain_cq(input int limit);
		int cycles;
		cycles = 0;
		while (exp_cq.size() > 0 && !timed_out) begin
			if (cycles >= limit) begin
				note_timeout("cq entries never retired");
			end else begin
				drive_side(1'b0, 1'b1);
				@(negedge CLK);
				cycles++;
			end
		end
		clear_dispatch();
	endtask

	task automatic end_test(input string name, input int errs_before);
		n_tests++;
		if (error_count != errs_before || timed_out) begin
			n_failed++;
			$display("test %s: failed", name);
		end else begin
			$display("test %s: passed", name);
		end
	endtask

	// ------------------------------------------------------------
	// test sequence

	initial begin
		int e;
		int sent;
		nRST = 1'b0;
		rob_restart_valid = 1'b0;
		dispatch_op_by_way = '0;
		dispatch_imm12_by_way = '0;
		dispatch_mdp_info_by_way = '0;
		dispatch_A_PR_by_way = '0;
		dispatch_A_ready_by_way = '0;
		dispatch_A_is_zero_by_way = '0;
		dispatch_dest_PR_by_way = '0;
		dispatch_ROB_index_by_way = '0;
		clear_dispatch();
		repeat (10) @(negedge CLK);
		if (dispatch_ack_by_way != 0 || issue_valid || cq_head_valid) begin
			fail_value("outputs not idle in reset");
		end
		nRST = 1'b1;

		e = error_count;
		build_ops(12, 1);
		send_ops(0, 12, 1'b0, 1'b1, 1'b0, 50, sent);
		if (sent != 12) begin
			fail_value($sformatf("%0d of 12 ready ops accepted", sent));
		end
		drain_issue(200, 1'b1);
		drain_cq(200);
		end_test("ready ops in order", e);

		e = error_count;
		build_ops(16, 2);
		send_ops(0, 16, 1'b1, 1'b1, 1'b1, 100, sent);
		if (sent != 16) begin
			fail_value($sformatf("%0d of 16 mixed ops accepted", sent));
		end
		drain_issue(400, 1'b1);
		drain_cq(200);
		end_test("writeback wakeup", e);

		// no writebacks and no retires until acks stop
		e = error_count;
		pr_written = '0;
		build_ops(20, 0);
		send_ops(0, 20, 1'b0, 1'b0, 1'b1, 30, sent);
		if (sent > 16 || sent < 8) begin
			fail_value($sformatf("%0d ops acked with nothing leaving", sent));
		end
		send_ops(sent, 20, 1'b1, 1'b1, 1'b1, 200, sent);
		if (sent != 20) begin
			fail_value($sformatf("%0d of 20 ops accepted after resume", sent));
		end
		drain_issue(400, 1'b1);
		drain_cq(200);
		end_test("back-pressure", e);

		e = error_count;
		retire = 1'b1;
		@(negedge CLK);
		retire = 1'b0;
		if (cq_head_valid) begin
			fail_value("retire on empty cq left a head");
		end
		build_ops(5, 1);
		send_ops(0, 5, 1'b0, 1'b0, 1'b0, 50, sent);
		if (sent != 5) begin
			fail_value($sformatf("%0d of 5 ops accepted", sent));
		end
		drain_issue(100, 1'b0);
		drain_cq(100);
		end_test("cq head and retire", e);

		e = error_count;
		build_ops(6, 2);
		send_ops(0, 6, 1'b0, 1'b0, 1'b0, 40, sent);
		rob_restart_valid = 1'b1;
		// an op offered during restart must not be taken
		dispatch_attempt_by_way = 4'b0001;
		dispatch_valid_by_way = 4'b0001;
		@(negedge CLK);
		rob_restart_valid = 1'b0;
		clear_dispatch();
		if (cq_head_valid) begin
			fail_value("cq head valid after restart");
		end
		// wake every PR so a surviving op would show up
		for (int c = 0; c < 16; c++) begin
			WB_bus_valid_by_bank = 4'hf;
			WB_bus_upper_PR_by_bank = {4{4'(c)}};
			@(negedge CLK);
		end
		clear_dispatch();
		build_ops(4, 1);
		send_ops(0, 4, 1'b0, 1'b1, 1'b0, 50, sent);
		if (sent != 4) begin
			fail_value($sformatf("%0d of 4 ops accepted after restart", sent));
		end
		drain_issue(100, 1'b1);
		drain_cq(100);
		end_test("restart", e);

		$display("tests %0d, failed %0d, checks %0d, errors %0d", n_tests, n_failed,
			check_count, error_count);
		if (error_count == 0 && !timed_out) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule
